//--- all.f
+incdir+.
macPkg.sv
macUnit.sv
macRow.sv
macGrid.sv
operandSkew.sv
resultDeskew.sv
convCore.sv
tbChecker.sv
tbConvCore.sv

//--- convCore.sv
`timescale 1ns/1ns
`include "mac_settings.svh"

module convCore (
  input  logic                  iClk,
  input  logic                  reset,
  input  macPkg::weightCtrl_t   ctrlIn,
  input  macPkg::gridData_t     dataIn,
  input  logic [`MAC_LANES-2:0] passLeft,
  input  logic [4:0]            outShift,
  output macPkg::gridResult_t   result,
  output logic                  resultValid
);

  macPkg::gridData_t                  skewed;
  macPkg::rowResult_t [`MAC_ROWS-1:0] rowResults;

  // ------------------------------------------------------------
  // skew, compute, deskew
  // ------------------------------------------------------------

  operandSkew uSkew (
    .iClk    (iClk),
    .reset   (reset),
    .dataIn  (dataIn),
    .dataOut (skewed)
  );

  macGrid uGrid (
    .iClk     (iClk),
    .reset    (reset),
    .ctrlIn   (ctrlIn),
    .data     (skewed),
    .passLeft (passLeft),  // delayed inside the grid to follow the weight
    .outShift (outShift),
    .rowOut   (rowResults)
  );

  resultDeskew uDeskew (
    .iClk        (iClk),
    .reset       (reset),
    .rowIn       (rowResults),
    .result      (result),
    .resultValid (resultValid)
  );

endmodule

//--- macGrid.sv
`timescale 1ns/1ns
`include "mac_settings.svh"

module macGrid (
  input  logic                                   iClk,
  input  logic                                   reset,
  input  macPkg::weightCtrl_t                    ctrlIn,
  input  macPkg::gridData_t                      data,
  input  logic [`MAC_LANES-2:0]                  passLeft,
  input  logic [4:0]                             outShift,
  output macPkg::rowResult_t [`MAC_ROWS-1:0]     rowOut
);

  macPkg::weightCtrl_t        ctrlChain [`MAC_ROWS+1];
  logic [`MAC_LANES-2:0]      passDly [`MAC_ROWS-1];  // entry k is k+1 cycles late

  assign ctrlChain[0] = ctrlIn;

  // ------------------------------------------------------------
  // pass-left mask follows the weight down the rows
  // ------------------------------------------------------------

  always_ff @(posedge iClk) begin
    if (reset) begin
      for (int k = 0; k < `MAC_ROWS - 1; k++) begin
        passDly[k] <= '0;
      end
    end else begin
      passDly[0] <= passLeft;
      for (int k = 1; k < `MAC_ROWS - 1; k++) begin
        passDly[k] <= passDly[k-1];
      end
    end
  end

  // ------------------------------------------------------------
  // rows
  // ------------------------------------------------------------

  for (genvar r = 0; r < `MAC_ROWS; r++) begin : gRow
    logic [`MAC_LANES-2:0] rowPass;

    if (r == 0) begin : gTop
      assign rowPass = passLeft;
    end else begin : gBelow
      assign rowPass = passDly[r-1];

      validFromAbove: assert property (@(posedge iClk) disable iff (reset)
        $rose(rowOut[r].valid) |-> $past(rowOut[r-1].valid))
        else $error("macGrid: row %0d valid without the row above", r);
    end

    macRow uRow (
      .iClk     (iClk),
      .reset    (reset),
      .ctrlIn   (ctrlChain[r]),
      .data     (data.row[r]),
      .passLeft (rowPass),
      .outShift (outShift),
      .ctrlOut  (ctrlChain[r+1]),
      .rowOut   (rowOut[r])
    );
  end

endmodule

//--- macPkg.sv
`include "mac_settings.svh"

package macPkg;

  // ------------------------------------------------------------
  // operands
  // ------------------------------------------------------------

  typedef struct packed {
    logic signed [7:0] weight;
    logic              clear;  // marks the last term of an accumulation
  } weightCtrl_t;

  typedef struct packed {
    logic [`MAC_LANES-1:0][7:0] act;  // lane 0 is the leftmost lane
  } rowData_t;

  typedef struct packed {
    rowData_t [`MAC_ROWS-1:0] row;
  } gridData_t;

  // ------------------------------------------------------------
  // results
  // ------------------------------------------------------------

  typedef struct packed {
    logic [`MAC_LANES-1:0][7:0] lane;  // saturated signed results
    logic                       valid;
  } rowResult_t;

  typedef struct packed {
    logic [`MAC_ROWS-1:0][`MAC_LANES-1:0][7:0] row;
  } gridResult_t;

endpackage

//--- macRow.sv
`timescale 1ns/1ns
`include "mac_settings.svh"

module macRow (
  input  logic                  iClk,
  input  logic                  reset,
  input  macPkg::weightCtrl_t   ctrlIn,
  input  macPkg::rowData_t      data,
  input  logic [`MAC_LANES-2:0] passLeft,
  input  logic [4:0]            outShift,
  output macPkg::weightCtrl_t   ctrlOut,
  output macPkg::rowResult_t    rowOut
);

  logic [`MAC_LANES-1:0][7:0] held;
  logic [`MAC_LANES-1:0][7:0] laneResult;
  logic [`MAC_LANES-1:0]      laneValid;

  always_ff @(posedge iClk) begin
    if (reset) begin
      ctrlOut <= '0;
    end else begin
      ctrlOut <= ctrlIn;  // the row below sees this weight one cycle later
    end
  end

  // ------------------------------------------------------------
  // lanes
  // ------------------------------------------------------------

  for (genvar l = 0; l < `MAC_LANES; l++) begin : gLane
    logic [7:0] rightHeld;
    logic       takeRight;

    if (l == `MAC_LANES - 1) begin : gEdge
      assign rightHeld = '0;  // nothing to the right of the last lane
      assign takeRight = 1'b0;
    end else begin : gInner
      assign rightHeld = held[l+1];
      assign takeRight = passLeft[l];  // bit l is the boundary between l and l+1
    end

    macUnit uUnit (
      .iClk          (iClk),
      .reset         (reset),
      .ownData       (data.act[l]),
      .neighbourData (rightHeld),
      .takeNeighbour (takeRight),
      .weight        (ctrlIn.weight),
      .clear         (ctrlIn.clear),
      .outShift      (outShift),
      .heldData      (held[l]),
      .result        (laneResult[l]),
      .resultValid   (laneValid[l])
    );
  end

  assign rowOut.lane  = laneResult;
  assign rowOut.valid = laneValid[0];  // every lane sees the same clear

endmodule

//--- macUnit.sv
`timescale 1ns/1ns
`include "mac_settings.svh"

module macUnit (
  input  logic              iClk,
  input  logic              reset,
  input  logic signed [7:0] ownData,
  input  logic signed [7:0] neighbourData,
  input  logic              takeNeighbour,
  input  logic signed [7:0] weight,
  input  logic              clear,
  input  logic [4:0]        outShift,
  output logic [7:0]        heldData,
  output logic signed [7:0] result,
  output logic              resultValid
);

  logic signed [7:0]            operand;
  logic signed [15:0]           product;
  logic signed [`ACC_WIDTH-1:0] acc;
  logic signed [`ACC_WIDTH-1:0] sum;
  logic signed [`ACC_WIDTH-1:0] scaled;
  logic signed [7:0]            saturated;

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  assign operand = takeNeighbour ? neighbourData : ownData;  // slide the window left
  assign product = operand * weight;
  assign sum     = acc + product;  // sum includes the current term
  assign scaled  = sum >>> outShift;  // arithmetic, keeps the sign

  always_comb begin
    if (scaled > 127) begin
      saturated = 8'sd127;
    end else if (scaled < -128) begin
      saturated = -8'sd128;
    end else begin
      saturated = scaled[7:0];
    end
  end

  // ------------------------------------------------------------
  // state
  // ------------------------------------------------------------

  always_ff @(posedge iClk) begin
    if (reset) begin
      acc         <= '0;
      heldData    <= '0;
      resultValid <= 1'b0;
    end else begin
      heldData    <= operand;  // seen by the left neighbour next cycle
      resultValid <= clear;
      acc         <= clear ? '0 : sum;  // next accumulation starts fresh
    end
  end

  always_ff @(posedge iClk) begin
    if (clear) begin
      result <= saturated;
    end
  end

  clearKnown: assert property (@(posedge iClk) disable iff (reset) !$isunknown(clear))
    else $error("macUnit: clear is unknown");

endmodule

//--- mac_settings.svh
`ifndef MAC_SETTINGS_SVH
`define MAC_SETTINGS_SVH

// ------------------------------------------------------------
// grid geometry
// ------------------------------------------------------------

// lanes per row, every lane of a row sees the same weight
`define MAC_LANES 3

`define MAC_ROWS 3  // rows, each one a cycle behind the row above

// ------------------------------------------------------------
// arithmetic
// ------------------------------------------------------------

`define ACC_WIDTH 24  // wide enough for long 8x8 dot products

`endif

//--- operandSkew.sv
`timescale 1ns/1ns
`include "mac_settings.svh"

module operandSkew (
  input  logic              iClk,
  input  logic              reset,
  input  macPkg::gridData_t dataIn,
  output macPkg::gridData_t dataOut
);

  // ------------------------------------------------------------
  // triangle of delay stages, row r waits r cycles
  // ------------------------------------------------------------

  for (genvar r = 0; r < `MAC_ROWS; r++) begin : gRow
    if (r == 0) begin : gDirect
      assign dataOut.row[0] = dataIn.row[0];  // top row meets the weight at once
    end else begin : gDelay
      macPkg::rowData_t pipe [r];

      always_ff @(posedge iClk) begin
        if (reset) begin
          for (int s = 0; s < r; s++) begin
            pipe[s] <= '0;
          end
        end else begin
          pipe[0] <= dataIn.row[r];
          for (int s = 1; s < r; s++) begin
            pipe[s] <= pipe[s-1];
          end
        end
      end

      assign dataOut.row[r] = pipe[r-1];
    end
  end

endmodule

//--- resultDeskew.sv
`timescale 1ns/1ns
`include "mac_settings.svh"

module resultDeskew (
  input  logic                               iClk,
  input  logic                               reset,
  input  macPkg::rowResult_t [`MAC_ROWS-1:0] rowIn,
  output macPkg::gridResult_t                result,
  output logic                               resultValid
);

  macPkg::rowResult_t [`MAC_ROWS-1:0] aligned;
  logic [`MAC_ROWS-1:0]               alignedValid;

  // ------------------------------------------------------------
  // upper rows finish early and wait for the bottom row
  // ------------------------------------------------------------

  for (genvar r = 0; r < `MAC_ROWS; r++) begin : gRow
    localparam int Depth = `MAC_ROWS - 1 - r;

    if (Depth == 0) begin : gDirect
      assign aligned[r] = rowIn[r];  // bottom row sets the pace
    end else begin : gDelay
      macPkg::rowResult_t pipe [Depth];

      always_ff @(posedge iClk) begin
        if (reset) begin
          for (int s = 0; s < Depth; s++) begin
            pipe[s] <= '0;
          end
        end else begin
          pipe[0] <= rowIn[r];
          for (int s = 1; s < Depth; s++) begin
            pipe[s] <= pipe[s-1];
          end
        end
      end

      assign aligned[r] = pipe[Depth-1];
    end

    assign result.row[r]   = aligned[r].lane;
    assign alignedValid[r] = aligned[r].valid;
  end

  assign resultValid = alignedValid[`MAC_ROWS-1];

  rowsAgree: assert property (@(posedge iClk) disable iff (reset)
    alignedValid == '0 || alignedValid == '1)
    else $error("resultDeskew: row valids out of step, %b", alignedValid);

endmodule

//--- tbChecker.sv
`timescale 1ns/1ns
`include "mac_settings.svh"

module tbChecker (
  input  logic                  iClk,
  input  logic                  reset,
  input  macPkg::weightCtrl_t   ctrlIn,
  input  macPkg::gridData_t     dataIn,
  input  logic [`MAC_LANES-2:0] passLeft,
  input  logic [4:0]            outShift,
  input  macPkg::gridResult_t   result,
  input  logic                  resultValid,
  output int                    passCount,
  output int                    failCount,
  output int                    doneCount
);

  longint              acc [`MAC_ROWS][`MAC_LANES];
  int                  held [`MAC_ROWS][`MAC_LANES];  // activation each lane took last term
  macPkg::gridResult_t expectQ [$];
  int                  dueQ [$];  // cycle in which each resultValid must arrive
  int                  testQ [$];
  int                  cycle = 0;
  int                  clears = 0;
  int                  testsPassed = 0;
  int                  testsFailed = 0;
  int                  strays = 0;

  assign passCount = testsPassed;
  assign failCount = testsFailed + strays;
  assign doneCount = testsPassed + testsFailed;

  function automatic logic [7:0] saturate(longint value);
    if (value > 127) begin
      return 8'h7f;
    end
    if (value < -128) begin
      return 8'h80;
    end
    return value[7:0];
  endfunction

  task automatic clearModel();
    for (int r = 0; r < `MAC_ROWS; r++) begin
      for (int l = 0; l < `MAC_LANES; l++) begin
        acc[r][l]  = 0;
        held[r][l] = 0;
      end
    end
    expectQ.delete();
    dueQ.delete();
    testQ.delete();
  endtask

  // ------------------------------------------------------------
  // reference model, all rows seen in top-level time
  // ------------------------------------------------------------

  task automatic stepModel();
    int                  w;
    int                  operand [`MAC_LANES];
    longint              sum;
    macPkg::gridResult_t expected;
    w        = $signed(ctrlIn.weight);
    expected = '0;
    for (int r = 0; r < `MAC_ROWS; r++) begin
      for (int l = 0; l < `MAC_LANES; l++) begin
        if (l < `MAC_LANES - 1 && passLeft[l]) begin
          operand[l] = held[r][l+1];  // right neighbour's activation from the last term
        end else begin
          operand[l] = $signed(dataIn.row[r].act[l]);
        end
      end
      for (int l = 0; l < `MAC_LANES; l++) begin
        sum        = acc[r][l] + operand[l] * w;
        held[r][l] = operand[l];
        if (ctrlIn.clear === 1'b1) begin
          expected.row[r][l] = saturate(sum >>> outShift);
          acc[r][l]          = 0;
        end else begin
          acc[r][l] = sum;
        end
      end
    end
    if (ctrlIn.clear === 1'b1) begin
      expectQ.push_back(expected);
      dueQ.push_back(cycle + `MAC_ROWS);
      testQ.push_back(clears);
      clears++;
    end
  endtask

  task automatic checkOutputs();
    int wrong;
    if (resultValid === 1'b1) begin
      if (dueQ.size() == 0) begin
        $display("resultValid pulsed at cycle %0d with no result pending", cycle);
        strays++;
      end else if (dueQ[0] != cycle) begin
        $display("resultValid at cycle %0d came early, test %0d is due at cycle %0d",
                 cycle, testQ[0], dueQ[0]);
        strays++;
      end else begin
        wrong = 0;
        for (int r = 0; r < `MAC_ROWS; r++) begin
          for (int l = 0; l < `MAC_LANES; l++) begin
            if (result.row[r][l] !== expectQ[0].row[r][l]) begin
              $display("error result.row[%0d][%0d] test %0d expected %h actual %h",
                       r, l, testQ[0], expectQ[0].row[r][l], result.row[r][l]);
              wrong++;
            end
          end
        end
        if (wrong == 0) begin
          $display("test %0d ok, result %h after %0d cycles", testQ[0], result, `MAC_ROWS);
          testsPassed++;
        end else begin
          $display("test %0d failed with %0d wrong lanes", testQ[0], wrong);
          testsFailed++;
        end
        void'(expectQ.pop_front());
        void'(dueQ.pop_front());
        void'(testQ.pop_front());
      end
    end else if (resultValid !== 1'b0) begin
      $display("resultValid is unknown at cycle %0d", cycle);
      strays++;
    end else if (dueQ.size() > 0 && dueQ[0] == cycle) begin
      $display("test %0d failed, no resultValid %0d cycles after its clear",
               testQ[0], `MAC_ROWS);
      testsFailed++;
      void'(expectQ.pop_front());
      void'(dueQ.pop_front());
      void'(testQ.pop_front());
    end
  endtask

  // inputs and outputs are both settled at the falling edge
  always @(negedge iClk) begin
    cycle++;
    if (reset) begin
      if (resultValid !== 1'b0) begin
        $display("resultValid is not low during reset at cycle %0d", cycle);
        strays++;
      end
      clearModel();
    end else begin
      checkOutputs();
      stepModel();
    end
  end

endmodule

//--- tbConvCore.sv
`timescale 1ns/1ns
`include "mac_settings.svh"

module tbConvCore;

  localparam int ClkPeriod   = 4;
  localparam int ResetCycles = 16;
  localparam int IdleGap     = `MAC_ROWS + 3;  // lets every row finish before the shift changes
  localparam int DrainCycles = `MAC_ROWS + 6;
  localparam int NumTests    = 11;

  logic                  iClk;
  logic                  reset;
  macPkg::weightCtrl_t   ctrlIn;
  macPkg::gridData_t     dataIn;
  logic [`MAC_LANES-2:0] passLeft;
  logic [4:0]            outShift;
  macPkg::gridResult_t   result;
  logic                  resultValid;
  int                    passCount;
  int                    failCount;
  int                    doneCount;
  logic [31:0]           rngState;

  // ------------------------------------------------------------
  // stimulus table, one column per field
  // ------------------------------------------------------------

  string names [NumTests] = '{"reset_zero", "dot_small", "shift_small", "shift_full",
                              "saturate", "slide_all", "slide_one", "chain_a",
                              "chain_b", "chain_c", "chain_d"};
  int    terms [NumTests]     = '{4, 8, 10, 6, 8, 9, 7, 5, 3, 1, 2};
  int    shifts [NumTests]    = '{0, 0, 2, 9, 0, 0, 1, 1, 1, 1, 1};
  int    masks [NumTests]     = '{0, 0, 0, 0, 0, 3, 1, 0, 2, 3, 0};
  bit    fullScale [NumTests] = '{0, 0, 0, 1, 1, 0, 0, 0, 0, 0, 1};
  bit    chained [NumTests]   = '{0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 0};  // next test starts at once

  convCore DUT (
    .iClk        (iClk),
    .reset       (reset),
    .ctrlIn      (ctrlIn),
    .dataIn      (dataIn),
    .passLeft    (passLeft),
    .outShift    (outShift),
    .result      (result),
    .resultValid (resultValid)
  );

  tbChecker uChecker (
    .iClk        (iClk),
    .reset       (reset),
    .ctrlIn      (ctrlIn),
    .dataIn      (dataIn),
    .passLeft    (passLeft),
    .outShift    (outShift),
    .result      (result),
    .resultValid (resultValid),
    .passCount   (passCount),
    .failCount   (failCount),
    .doneCount   (doneCount)
  );

  initial begin
    iClk = 1'b0;
    forever begin
      #(ClkPeriod / 2) iClk = ~iClk;
    end
  end

  function automatic logic [31:0] xorshift(logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic drawOperand(input bit full, output logic [7:0] value);
    rngState = xorshift(rngState);
    if (full) begin
      value = rngState[7:0];
    end else begin
      value = {{4{rngState[3]}}, rngState[3:0]};  // small range, -8 to 7
    end
  endtask

  task automatic driveTerm(input int test, input bit last);
    macPkg::weightCtrl_t ctrl;
    macPkg::gridData_t   data;
    logic [7:0]          value;
    drawOperand(fullScale[test], value);
    ctrl.weight = value;
    ctrl.clear  = last;
    for (int r = 0; r < `MAC_ROWS; r++) begin
      for (int l = 0; l < `MAC_LANES; l++) begin
        drawOperand(fullScale[test], value);
        data.row[r].act[l] = value;
      end
    end
    ctrlIn   <= ctrl;
    dataIn   <= data;
    passLeft <= masks[test][`MAC_LANES-2:0];
    outShift <= shifts[test][4:0];
  endtask

  // ------------------------------------------------------------
  // run the table
  // ------------------------------------------------------------

  initial begin : stimulus
    reset    = 1'b1;
    ctrlIn   = '0;
    dataIn   = '0;
    passLeft = '0;
    outShift = '0;
    rngState = 32'h75e2b00d;
    repeat (ResetCycles) @(posedge iClk);
    reset <= 1'b0;
    for (int k = 0; k < NumTests; k++) begin
      $display("test %0d %s: %0d terms, shift %0d, mask %0h",
               k, names[k], terms[k], shifts[k], masks[k]);
      for (int n = 0; n < terms[k]; n++) begin
        @(posedge iClk);
        driveTerm(k, n == terms[k] - 1);
      end
      if (!chained[k]) begin
        repeat (IdleGap) begin
          @(posedge iClk);
          ctrlIn <= '0;
          dataIn <= '0;
        end
      end
    end
    while (doneCount < NumTests) begin
      @(posedge iClk);
    end
    repeat (DrainCycles) @(posedge iClk);  // catch any stray valid
    $display("tests passed %0d of %0d, failures %0d", passCount, NumTests, failCount);
    if (failCount == 0 && passCount == NumTests) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    limit = ResetCycles + DrainCycles + 50;
    for (int k = 0; k < NumTests; k++) begin
      limit = limit + terms[k];
      if (!chained[k]) begin
        limit = limit + IdleGap;
      end
    end
    #(limit * ClkPeriod);
    $display("timeout, the run did not finish within %0d cycles", limit);
    $display("Something failed");
    $finish;
  end

endmodule
